// File: csr_pkg.sv
// LoongArch-style 32-bit CSR layout, exception and timer subset only; no TLB registers exist
`default_nettype none

package csr_pkg;

    // basic widths
    localparam int csr_num_w = 14;
    localparam int xlen      = 32;

    // CSR numbers
    localparam logic [csr_num_w-1:0] csr_crmd   = 14'h0;
    localparam logic [csr_num_w-1:0] csr_prmd   = 14'h1;
    localparam logic [csr_num_w-1:0] csr_ecfg   = 14'h4;
    localparam logic [csr_num_w-1:0] csr_estat  = 14'h5;
    localparam logic [csr_num_w-1:0] csr_era    = 14'h6;
    localparam logic [csr_num_w-1:0] csr_badv   = 14'h7;
    localparam logic [csr_num_w-1:0] csr_eentry = 14'hc;
    localparam logic [csr_num_w-1:0] csr_save0  = 14'h30;
    localparam logic [csr_num_w-1:0] csr_save1  = 14'h31;
    localparam logic [csr_num_w-1:0] csr_save2  = 14'h32;
    localparam logic [csr_num_w-1:0] csr_save3  = 14'h33;
    localparam logic [csr_num_w-1:0] csr_tid    = 14'h40;
    localparam logic [csr_num_w-1:0] csr_tcfg   = 14'h41;
    localparam logic [csr_num_w-1:0] csr_tval   = 14'h42;
    localparam logic [csr_num_w-1:0] csr_ticlr  = 14'h44;

    // field positions
    localparam int crmd_plv_lo    = 0;   // also PPLV in PRMD
    localparam int crmd_ie_bit    = 2;
    localparam int crmd_da_bit    = 3;
    localparam int prmd_pie_bit   = 2;
    localparam int estat_ecode_lo = 16;
    localparam int estat_esub_lo  = 22;
    localparam int eentry_va_lo   = 6;
    localparam int tcfg_en_bit    = 0;
    localparam int tcfg_per_bit   = 1;
    localparam int tcfg_initv_lo  = 2;
    localparam int ticlr_clr_bit  = 0;

    // interrupt and exception widths
    localparam int int_w        = 13;
    localparam int hw_int_w     = 8;
    localparam int ecode_w      = 6;
    localparam int esub_w       = 9;
    localparam int plv_w        = 2;
    localparam int timer_is_bit = 11;
    localparam int ipi_is_bit   = 12;

    // local enable bit 10 has no source, so it stays zero
    localparam logic [int_w-1:0] ecfg_lie_mask = 13'h1bff;

    // exception codes
    localparam logic [ecode_w-1:0] ecode_ade     = 6'h8;
    localparam logic [ecode_w-1:0] ecode_ale     = 6'h9;
    localparam logic [esub_w-1:0]  esubcode_adef = 9'h0;

    localparam logic [xlen-1:0] timer_idle = 32'hffff_ffff; // stopped timer rests here

    // masked write: take new bits where mask is set, keep old bits elsewhere
    function automatic logic [xlen-1:0] masked_merge(input logic [xlen-1:0] old_val,
                                                     input logic [xlen-1:0] wvalue,
                                                     input logic [xlen-1:0] wmask);
        return (wmask & wvalue) | (~wmask & old_val);
    endfunction

endpackage

`default_nettype wire

// File: csr_mode_fsm.sv
// CRMD/PRMD mode state; DA reads 1 and PG/DATF/DATM read 0, none of them writable
`timescale 1ns/1ns
`default_nettype none

module csr_mode_fsm (
    input  wire                          clk,
    input  wire                          resetn,
    input  wire                          wb_ex,
    input  wire                          ertn_flush,
    input  wire                          csr_we,
    input  wire [csr_pkg::csr_num_w-1:0] csr_num,
    input  wire [csr_pkg::xlen-1:0]      csr_wmask,
    input  wire [csr_pkg::xlen-1:0]      csr_wvalue,
    output logic                         crmd_ie,
    output logic [csr_pkg::xlen-1:0]     rdata
);
    import csr_pkg::*;

    // current mode and saved mode
    logic [plv_w-1:0] plv_q;
    logic             ie_q;
    logic [plv_w-1:0] pplv_q;
    logic             pie_q;

    logic [xlen-1:0] crmd_val;
    logic [xlen-1:0] prmd_val;
    logic [xlen-1:0] crmd_new;
    logic [xlen-1:0] prmd_new;
    logic            crmd_wr;
    logic            prmd_wr;

    assign crmd_wr = csr_we && (csr_num == csr_crmd);
    assign prmd_wr = csr_we && (csr_num == csr_prmd);

    always_comb begin
        crmd_val                           = '0;
        crmd_val[crmd_plv_lo +: plv_w]     = plv_q;
        crmd_val[crmd_ie_bit]              = ie_q;
        crmd_val[crmd_da_bit]              = 1'b1;  // direct address mode only
        prmd_val                           = '0;
        prmd_val[crmd_plv_lo +: plv_w]     = pplv_q;
        prmd_val[prmd_pie_bit]             = pie_q;
    end

    assign crmd_new = masked_merge(crmd_val, csr_wvalue, csr_wmask);
    assign prmd_new = masked_merge(prmd_val, csr_wvalue, csr_wmask);

    // current mode: entry drops to kernel with interrupts off, return restores
    always_ff @(posedge clk) begin
        if (!resetn) begin
            plv_q <= '0;
            ie_q  <= 1'b0;
        end else if (wb_ex) begin
            plv_q <= '0;
            ie_q  <= 1'b0;
        end else if (ertn_flush) begin
            plv_q <= pplv_q;
            ie_q  <= pie_q;
        end else if (crmd_wr) begin
            plv_q <= crmd_new[crmd_plv_lo +: plv_w];
            ie_q  <= crmd_new[crmd_ie_bit];
        end
    end

    // saved mode, captured on entry
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pplv_q <= '0;
            pie_q  <= 1'b0;
        end else if (wb_ex) begin
            pplv_q <= plv_q;
            pie_q  <= ie_q;
        end else if (prmd_wr) begin
            pplv_q <= prmd_new[crmd_plv_lo +: plv_w];
            pie_q  <= prmd_new[prmd_pie_bit];
        end
    end

    assign crmd_ie = ie_q;

    assign rdata = (csr_num == csr_crmd) ? crmd_val :
                   (csr_num == csr_prmd) ? prmd_val : '0;

endmodule

`default_nettype wire

// File: csr_timer.sv
// TCFG and TVAL; count is initval*4 and a one-shot timer parks at all ones until rewritten
`timescale 1ns/1ns
`default_nettype none

module csr_timer (
    input  wire                          clk,
    input  wire                          resetn,
    input  wire                          csr_we,
    input  wire [csr_pkg::csr_num_w-1:0] csr_num,
    input  wire [csr_pkg::xlen-1:0]      csr_wmask,
    input  wire [csr_pkg::xlen-1:0]      csr_wvalue,
    output logic                         timer_zero,
    output logic [csr_pkg::xlen-1:0]     rdata
);
    import csr_pkg::*;

    logic                          tcfg_en;
    logic                          tcfg_per;
    logic [xlen-tcfg_initv_lo-1:0] tcfg_initv;
    logic [xlen-1:0]               timer_cnt;

    logic [xlen-1:0] tcfg_val;
    logic [xlen-1:0] tcfg_next;  // TCFG value after this cycle's write
    logic            tcfg_wr;

    assign tcfg_wr = csr_we && (csr_num == csr_tcfg);

    always_comb begin
        tcfg_val                                     = '0;
        tcfg_val[tcfg_en_bit]                        = tcfg_en;
        tcfg_val[tcfg_per_bit]                       = tcfg_per;
        tcfg_val[xlen-1:tcfg_initv_lo]               = tcfg_initv;
    end

    assign tcfg_next = masked_merge(tcfg_val, csr_wvalue, csr_wmask);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tcfg_en    <= 1'b0;
            tcfg_per   <= 1'b0;
            tcfg_initv <= '0;
        end else if (tcfg_wr) begin
            tcfg_en    <= tcfg_next[tcfg_en_bit];
            tcfg_per   <= tcfg_next[tcfg_per_bit];
            tcfg_initv <= tcfg_next[xlen-1:tcfg_initv_lo];
        end
    end

    // down counter
    // a write that leaves enable set restarts the count at the same edge
    always_ff @(posedge clk) begin
        if (!resetn) begin
            timer_cnt <= timer_idle;
        end else if (tcfg_wr && tcfg_next[tcfg_en_bit]) begin
            timer_cnt <= {tcfg_next[xlen-1:tcfg_initv_lo], {tcfg_initv_lo{1'b0}}};
        end else if (tcfg_en && (timer_cnt != timer_idle)) begin
            if (timer_cnt == '0) begin
                if (tcfg_per)
                    timer_cnt <= {tcfg_initv, {tcfg_initv_lo{1'b0}}};  // periodic reload
                else
                    timer_cnt <= timer_idle;  // one-shot, stop
            end else begin
                timer_cnt <= timer_cnt - 32'd1;
            end
        end
    end

    assign timer_zero = (timer_cnt == '0);

    always_comb begin
        case (csr_num)
            csr_tcfg: rdata = tcfg_val;
            csr_tval: rdata = timer_cnt;
            default:  rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: csr_exc_regs.sv
// ECFG/ESTAT/ERA/BADV/EENTRY; ERA, BADV and EENTRY come up unknown, TICLR reads zero
`timescale 1ns/1ns
`default_nettype none

module csr_exc_regs (
    input  wire                          clk,
    input  wire                          resetn,
    input  wire                          csr_we,
    input  wire [csr_pkg::csr_num_w-1:0] csr_num,
    input  wire [csr_pkg::xlen-1:0]      csr_wmask,
    input  wire [csr_pkg::xlen-1:0]      csr_wvalue,
    input  wire                          wb_ex,
    input  wire [csr_pkg::ecode_w-1:0]   wb_ecode,
    input  wire [csr_pkg::esub_w-1:0]    wb_esubcode,
    input  wire [csr_pkg::xlen-1:0]      wb_pc,
    input  wire [csr_pkg::xlen-1:0]      wb_vaddr,
    input  wire [csr_pkg::hw_int_w-1:0]  hw_int_in,
    input  wire                          ipi_int_in,
    input  wire                          crmd_ie,
    input  wire                          timer_zero,
    output logic                         has_int,
    output logic [csr_pkg::xlen-1:0]     rdata
);
    import csr_pkg::*;

    logic [int_w-1:0]               ecfg_lie;
    logic [int_w-1:0]               estat_is;
    logic [ecode_w-1:0]             estat_ecode;
    logic [esub_w-1:0]              estat_esub;
    logic [xlen-1:0]                era_pc;
    logic [xlen-1:0]                badv_addr;
    logic [xlen-eentry_va_lo-1:0]   eentry_va;

    logic [xlen-1:0] estat_val;
    logic [xlen-1:0] eentry_val;
    logic [xlen-1:0] wr_merged;   // write data merged over the addressed register
    logic            ticlr_hit;
    logic            addr_err;
    logic            adef;

    always_comb begin
        estat_val                              = '0;
        estat_val[int_w-1:0]                   = estat_is;
        estat_val[estat_ecode_lo +: ecode_w]   = estat_ecode;
        estat_val[estat_esub_lo +: esub_w]     = estat_esub;
    end

    assign eentry_val = {eentry_va, {eentry_va_lo{1'b0}}};

    assign wr_merged = masked_merge(rdata, csr_wvalue, csr_wmask);

    assign ticlr_hit = csr_we && (csr_num == csr_ticlr)
                       && csr_wmask[ticlr_clr_bit] && csr_wvalue[ticlr_clr_bit];

    assign addr_err = (wb_ecode == ecode_ade) || (wb_ecode == ecode_ale);
    assign adef     = (wb_ecode == ecode_ade) && (wb_esubcode == esubcode_adef);

    always_ff @(posedge clk) begin
        if (!resetn)
            ecfg_lie <= '0;
        else if (csr_we && (csr_num == csr_ecfg))
            ecfg_lie <= wr_merged[int_w-1:0] & ecfg_lie_mask;
    end

    // interrupt status
    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_is <= '0;
        end else begin
            if (csr_we && (csr_num == csr_estat))
                estat_is[1:0] <= wr_merged[1:0];  // software interrupts
            estat_is[2 +: hw_int_w] <= hw_int_in;
            estat_is[2 + hw_int_w]  <= 1'b0;
            if (timer_zero)
                estat_is[timer_is_bit] <= 1'b1;  // set beats clear
            else if (ticlr_hit)
                estat_is[timer_is_bit] <= 1'b0;
            estat_is[ipi_is_bit] <= ipi_int_in;
        end
    end

    // exception cause
    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_ecode <= '0;
            estat_esub  <= '0;
        end else if (wb_ex) begin
            estat_ecode <= wb_ecode;
            estat_esub  <= wb_esubcode;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex)
            era_pc <= wb_pc;
        else if (csr_we && (csr_num == csr_era))
            era_pc <= wr_merged;

        if (wb_ex && addr_err)
            badv_addr <= adef ? wb_pc : wb_vaddr;  // fetch fault reports the pc
        else if (csr_we && (csr_num == csr_badv))
            badv_addr <= wr_merged;

        if (csr_we && (csr_num == csr_eentry))
            eentry_va <= wr_merged[xlen-1:eentry_va_lo];
    end

    assign has_int = crmd_ie && (|(estat_is & ecfg_lie));

    always_comb begin
        case (csr_num)
            csr_ecfg:   rdata = {{(xlen-int_w){1'b0}}, ecfg_lie};
            csr_estat:  rdata = estat_val;
            csr_era:    rdata = era_pc;
            csr_badv:   rdata = badv_addr;
            csr_eentry: rdata = eentry_val;
            default:    rdata = '0;  // includes TICLR
        endcase
    end

endmodule

`default_nettype wire

// File: csr_save_bank.sv
// SAVE0-3 scratch words start unknown after reset, TID starts at zero
`timescale 1ns/1ns
`default_nettype none

module csr_save_bank (
    input  wire                          clk,
    input  wire                          resetn,
    input  wire                          csr_we,
    input  wire [csr_pkg::csr_num_w-1:0] csr_num,
    input  wire [csr_pkg::xlen-1:0]      csr_wmask,
    input  wire [csr_pkg::xlen-1:0]      csr_wvalue,
    output logic [csr_pkg::xlen-1:0]     rdata
);
    import csr_pkg::*;

    logic [xlen-1:0] save_q [4];
    logic [xlen-1:0] tid_q;
    logic [1:0]      save_sel;
    logic            save_hit;

    // which scratch word, if any
    always_comb begin
        save_hit = 1'b1;
        save_sel = 2'd0;
        case (csr_num)
            csr_save0: save_sel = 2'd0;
            csr_save1: save_sel = 2'd1;
            csr_save2: save_sel = 2'd2;
            csr_save3: save_sel = 2'd3;
            default:   save_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (csr_we && save_hit)
            save_q[save_sel] <= masked_merge(save_q[save_sel], csr_wvalue, csr_wmask);
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            tid_q <= '0;
        else if (csr_we && (csr_num == csr_tid))
            tid_q <= masked_merge(tid_q, csr_wvalue, csr_wmask);
    end

    assign rdata = save_hit              ? save_q[save_sel] :
                   (csr_num == csr_tid)  ? tid_q            : '0;

endmodule

`default_nettype wire

// File: csr_file_top.sv
// CSR file top; csr_re is accepted for pipeline compatibility, reads are always live
`timescale 1ns/1ns
`default_nettype none

module csr_file_top (
    input  wire                          clk,
    input  wire                          resetn,
    input  wire                          csr_re,
    input  wire [csr_pkg::csr_num_w-1:0] csr_num,
    output logic [csr_pkg::xlen-1:0]     csr_rvalue,
    input  wire                          csr_we,
    input  wire [csr_pkg::xlen-1:0]      csr_wmask,
    input  wire [csr_pkg::xlen-1:0]      csr_wvalue,
    input  wire                          wb_ex,
    input  wire [csr_pkg::ecode_w-1:0]   wb_ecode,
    input  wire [csr_pkg::esub_w-1:0]    wb_esubcode,
    input  wire [csr_pkg::xlen-1:0]      wb_pc,
    input  wire [csr_pkg::xlen-1:0]      wb_vaddr,
    input  wire                          ertn_flush,
    input  wire [csr_pkg::hw_int_w-1:0]  hw_int_in,
    input  wire                          ipi_int_in,
    output logic                         has_int
);
    import csr_pkg::*;

    logic            crmd_ie;
    logic            timer_zero;
    logic [xlen-1:0] mode_rdata;
    logic [xlen-1:0] timer_rdata;
    logic [xlen-1:0] exc_rdata;
    logic [xlen-1:0] save_rdata;

    csr_mode_fsm u_mode (
        .clk        (clk),
        .resetn     (resetn),
        .wb_ex      (wb_ex),
        .ertn_flush (ertn_flush),
        .csr_we     (csr_we),
        .csr_num    (csr_num),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .crmd_ie    (crmd_ie),
        .rdata      (mode_rdata)
    );

    csr_timer u_timer (
        .clk        (clk),
        .resetn     (resetn),
        .csr_we     (csr_we),
        .csr_num    (csr_num),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .timer_zero (timer_zero),
        .rdata      (timer_rdata)
    );

    csr_exc_regs u_exc (
        .clk         (clk),
        .resetn      (resetn),
        .csr_we      (csr_we),
        .csr_num     (csr_num),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .hw_int_in   (hw_int_in),
        .ipi_int_in  (ipi_int_in),
        .crmd_ie     (crmd_ie),
        .timer_zero  (timer_zero),
        .has_int     (has_int),
        .rdata       (exc_rdata)
    );

    csr_save_bank u_save (
        .clk        (clk),
        .resetn     (resetn),
        .csr_we     (csr_we),
        .csr_num    (csr_num),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .rdata      (save_rdata)
    );

    // each group drives zero for numbers it does not own
    assign csr_rvalue = mode_rdata | timer_rdata | exc_rdata | save_rdata;

endmodule

`default_nettype wire

// File: csr_file_chk.sv
// has_int properties bound into csr_file_top; needs a simulator with concurrent assertion support
`timescale 1ns/1ns
`default_nettype none

module csr_file_chk (
    input wire clk,
    input wire resetn,
    input wire wb_ex,
    input wire crmd_ie,
    input wire has_int
);
    import csr_pkg::*;

    // a reset cycle clears IE and the enables
    int_low_after_reset: assert property (@(posedge clk) !resetn |=> !has_int)
        else $error("has_int high in the cycle after a reset edge");

    // entry turns interrupts off
    ie_off_after_entry: assert property (@(posedge clk) disable iff (!resetn) wb_ex |=> !crmd_ie)
        else $error("CRMD.IE still set in the cycle after an exception");

    int_off_after_entry: assert property (@(posedge clk) disable iff (!resetn) wb_ex |=> !has_int)
        else $error("has_int high in the cycle after an exception");

endmodule

bind csr_file_top csr_file_chk u_chk (
    .clk     (clk),
    .resetn  (resetn),
    .wb_ex   (wb_ex),
    .crmd_ie (crmd_ie),
    .has_int (has_int)
);

`default_nettype wire

// File: tb_csr_file.sv
// random traffic on csr_file_top against a cycle model; needs timing support, stops at first error
`timescale 1ns/1ns
`default_nettype none

module tb_csr_file;
    import csr_pkg::*;

    localparam int clk_half   = 2;
    localparam int reset_cyc  = 8;
    localparam int rand_cyc   = 6000;
    localparam int init_cyc   = 20;   // reset reads plus writes to the unreset registers
    localparam int timeout_ns = (reset_cyc + init_cyc + rand_cyc + 100) * 2 * clk_half;

    logic                 clk;
    logic                 resetn;
    logic                 csr_re;
    logic [csr_num_w-1:0] csr_num;
    logic [xlen-1:0]      csr_rvalue;
    logic                 csr_we;
    logic [xlen-1:0]      csr_wmask;
    logic [xlen-1:0]      csr_wvalue;
    logic                 wb_ex;
    logic [ecode_w-1:0]   wb_ecode;
    logic [esub_w-1:0]    wb_esubcode;
    logic [xlen-1:0]      wb_pc;
    logic [xlen-1:0]      wb_vaddr;
    logic                 ertn_flush;
    logic [hw_int_w-1:0]  hw_int_in;
    logic                 ipi_int_in;
    logic                 has_int;

    // reference model state
    logic [plv_w-1:0]   m_plv;
    logic               m_ie;
    logic [plv_w-1:0]   m_pplv;
    logic               m_pie;
    logic [int_w-1:0]   m_ecfg;
    logic [int_w-1:0]   m_is;
    logic [ecode_w-1:0] m_ecode;
    logic [esub_w-1:0]  m_esub;
    logic [xlen-1:0]    m_era;
    logic [xlen-1:0]    m_badv;
    logic [xlen-1:0]    m_eentry;
    logic [xlen-1:0]    m_save [4];
    logic [xlen-1:0]    m_tid;
    logic [xlen-1:0]    m_tcfg;
    logic [xlen-1:0]    m_cnt;

    logic [31:0] lfsr;

    csr_file_top u_csr_file_top (
        .clk         (clk),
        .resetn      (resetn),
        .csr_re      (csr_re),
        .csr_num     (csr_num),
        .csr_rvalue  (csr_rvalue),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .ertn_flush  (ertn_flush),
        .hw_int_in   (hw_int_in),
        .ipi_int_in  (ipi_int_in),
        .has_int     (has_int)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    initial begin
        #(timeout_ns);
        fail_now("watchdog ran out, the test did not reach its end");
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r = {r[30:0], next_bit()};
        return r;
    endfunction

    function automatic logic [xlen-1:0] merge_bits(input logic [xlen-1:0] old_val,
                                                   input logic [xlen-1:0] val,
                                                   input logic [xlen-1:0] mask);
        return (val & mask) | (old_val & ~mask);
    endfunction

    function automatic logic [xlen-1:0] model_read(input logic [csr_num_w-1:0] num);
        logic [xlen-1:0] r;
        r = '0;
        case (num)
            csr_crmd:   r = {28'h0, 1'b1, m_ie, m_plv};  // DA always set
            csr_prmd:   r = {29'h0, m_pie, m_pplv};
            csr_ecfg:   r = {19'h0, m_ecfg};
            csr_estat:  r = {1'b0, m_esub, m_ecode, 3'h0, m_is};
            csr_era:    r = m_era;
            csr_badv:   r = m_badv;
            csr_eentry: r = m_eentry;
            csr_save0:  r = m_save[0];
            csr_save1:  r = m_save[1];
            csr_save2:  r = m_save[2];
            csr_save3:  r = m_save[3];
            csr_tid:    r = m_tid;
            csr_tcfg:   r = m_tcfg;
            csr_tval:   r = m_cnt;
            default:    r = '0;
        endcase
        return r;
    endfunction

    task automatic model_reset();
        m_plv    = '0;
        m_ie     = 1'b0;
        m_pplv   = '0;
        m_pie    = 1'b0;
        m_ecfg   = '0;
        m_is     = '0;
        m_ecode  = '0;
        m_esub   = '0;
        m_era    = '0;  // no reset in hardware, written before any compare
        m_badv   = '0;
        m_eentry = '0;
        for (int i = 0; i < 4; i++)
            m_save[i] = '0;
        m_tid    = '0;
        m_tcfg   = '0;
        m_cnt    = timer_idle;
    endtask

    // one clock edge of the model, from the inputs held before the edge
    task automatic model_update();
        logic [xlen-1:0]  mv;
        logic [plv_w-1:0] o_plv;
        logic             o_ie;
        logic [xlen-1:0]  o_tcfg;
        logic             at_zero;
        logic             clr;
        mv      = merge_bits(model_read(csr_num), csr_wvalue, csr_wmask);
        o_plv   = m_plv;
        o_ie    = m_ie;
        o_tcfg  = m_tcfg;
        at_zero = (m_cnt == 32'h0);
        clr     = csr_we && (csr_num == csr_ticlr) && csr_wmask[0] && csr_wvalue[0];

        if (wb_ex) begin
            m_plv = '0;
            m_ie  = 1'b0;
        end else if (ertn_flush) begin
            m_plv = m_pplv;
            m_ie  = m_pie;
        end else if (csr_we && (csr_num == csr_crmd)) begin
            m_plv = mv[1:0];
            m_ie  = mv[2];
        end
        if (wb_ex) begin
            m_pplv = o_plv;
            m_pie  = o_ie;
        end else if (csr_we && (csr_num == csr_prmd)) begin
            m_pplv = mv[1:0];
            m_pie  = mv[2];
        end

        // timer
        if (csr_we && (csr_num == csr_tcfg))
            m_tcfg = mv;
        if (csr_we && (csr_num == csr_tcfg) && mv[0])
            m_cnt = {mv[31:2], 2'b00};
        else if (o_tcfg[0] && (m_cnt != timer_idle)) begin
            if (m_cnt == 32'h0)
                m_cnt = o_tcfg[1] ? {o_tcfg[31:2], 2'b00} : timer_idle;
            else
                m_cnt = m_cnt - 32'd1;
        end

        // interrupt status, hw and ipi lines one cycle late
        if (csr_we && (csr_num == csr_estat))
            m_is[1:0] = mv[1:0];
        m_is[9:2] = hw_int_in;
        m_is[10]  = 1'b0;
        if (at_zero)
            m_is[11] = 1'b1;
        else if (clr)
            m_is[11] = 1'b0;
        m_is[12] = ipi_int_in;

        if (wb_ex) begin
            m_ecode = wb_ecode;
            m_esub  = wb_esubcode;
            m_era   = wb_pc;
        end else if (csr_we && (csr_num == csr_era))
            m_era = mv;
        if (wb_ex && ((wb_ecode == 6'h8) || (wb_ecode == 6'h9)))
            m_badv = ((wb_ecode == 6'h8) && (wb_esubcode == 9'h0)) ? wb_pc : wb_vaddr;
        else if (csr_we && (csr_num == csr_badv))
            m_badv = mv;

        if (csr_we) begin
            case (csr_num)
                csr_ecfg:   m_ecfg = mv[int_w-1:0] & 13'h1bff;  // bit 10 stays clear
                csr_eentry: m_eentry = {mv[31:6], 6'h0};
                csr_save0, csr_save1, csr_save2, csr_save3: m_save[csr_num[1:0]] = mv;
                csr_tid:    m_tid = mv;
                default:    ;
            endcase
        end
    endtask

    task automatic next_edge();
        @(posedge clk);
        model_update();
        #1;
    endtask

    task automatic check_outputs(input logic chk_read);
        logic [xlen-1:0] exp_r;
        logic            exp_int;
        #2;
        exp_r   = model_read(csr_num);
        exp_int = m_ie && (|(m_is & m_ecfg));
        if (chk_read)
            assert (csr_rvalue == exp_r) else
                fail_now($sformatf("error: time %0t csr 0x%h read 0x%h expected 0x%h",
                                   $time, csr_num, csr_rvalue, exp_r));
        assert (has_int == exp_int) else
            fail_now($sformatf("error: time %0t has_int %b expected %b",
                               $time, has_int, exp_int));
    endtask

    task automatic expect_read(input logic [csr_num_w-1:0] num, input logic [xlen-1:0] exp);
        next_edge();
        csr_num = num;
        #2;
        assert (csr_rvalue == exp && !has_int) else
            fail_now($sformatf("error: time %0t after reset csr 0x%h read 0x%h expected 0x%h",
                               $time, num, csr_rvalue, exp));
    endtask

    task automatic init_write(input logic [csr_num_w-1:0] num);
        next_edge();
        csr_num    = num;
        csr_we     = 1'b1;
        csr_wmask  = 32'hffff_ffff;
        csr_wvalue = rand_bits(32);
        check_outputs(1'b0);  // old value still unknown
    endtask

    function automatic logic [csr_num_w-1:0] pick_num();
        logic [31:0] r;
        r = rand_bits(4);
        case (r[3:0])
            4'd0:    return csr_crmd;
            4'd1:    return csr_prmd;
            4'd2:    return csr_ecfg;
            4'd3:    return csr_estat;
            4'd4:    return csr_era;
            4'd5:    return csr_badv;
            4'd6:    return csr_eentry;
            4'd7:    return csr_save0;
            4'd8:    return csr_save1;
            4'd9:    return csr_save2;
            4'd10:   return csr_save3;
            4'd11:   return csr_tid;
            4'd12:   return csr_tcfg;
            4'd13:   return csr_tval;
            4'd14:   return csr_ticlr;
            default: begin
                r = rand_bits(csr_num_w);  // mostly unlisted numbers
                return r[csr_num_w-1:0];
            end
        endcase
    endfunction

    task automatic drive_random();
        logic [31:0] r;
        logic [4:0]  op;
        r          = rand_bits(5);
        op         = r[4:0];
        csr_num    = pick_num();
        r          = rand_bits(1);
        csr_wmask  = r[0] ? 32'hffff_ffff : rand_bits(32);
        csr_wvalue = rand_bits(32);
        if (csr_num == csr_tcfg) begin
            r          = rand_bits(6);
            csr_wvalue = {26'h0, r[5:0]};  // initval below 16 keeps the count short
        end
        wb_pc    = rand_bits(32);
        wb_vaddr = rand_bits(32);
        r        = rand_bits(2);
        if (r[1:0] == 2'd0)
            wb_ecode = 6'h8;
        else if (r[1:0] == 2'd1)
            wb_ecode = 6'h9;
        else begin
            r        = rand_bits(6);
            wb_ecode = r[5:0];
        end
        r = rand_bits(1);
        if (r[0])
            wb_esubcode = 9'h0;
        else begin
            r           = rand_bits(9);
            wb_esubcode = r[8:0];
        end
        r           = rand_bits(9);
        hw_int_in   = r[7:0];
        ipi_int_in  = r[8];
        csr_we      = (op < 5'd18);
        wb_ex       = (op == 5'd18);
        ertn_flush  = (op == 5'd19) || (op == 5'd20);
    endtask

    initial begin
        lfsr        = 32'h17b31669;
        resetn      = 1'b0;
        csr_re      = 1'b1;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ex       = 1'b0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        ertn_flush  = 1'b0;
        hw_int_in   = '0;
        ipi_int_in  = 1'b0;
        model_reset();
        repeat (reset_cyc) @(posedge clk);
        #1;
        resetn = 1'b1;

        expect_read(csr_crmd, 32'h0000_0008);
        expect_read(csr_prmd, 32'h0);
        expect_read(csr_ecfg, 32'h0);
        expect_read(csr_estat, 32'h0);
        expect_read(csr_tid, 32'h0);
        expect_read(csr_tcfg, 32'h0);
        expect_read(csr_tval, 32'hffff_ffff);

        init_write(csr_era);
        init_write(csr_badv);
        init_write(csr_eentry);
        init_write(csr_save0);
        init_write(csr_save1);
        init_write(csr_save2);
        init_write(csr_save3);

        repeat (rand_cyc) begin
            next_edge();
            drive_random();
            check_outputs(1'b1);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
csr_pkg.sv
csr_mode_fsm.sv
csr_timer.sv
csr_exc_regs.sv
csr_save_bank.sv
csr_file_top.sv
csr_file_chk.sv
tb_csr_file.sv

// File: run.sh
#!/bin/sh
# compile and run the CSR file testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_csr_file \
        -f filelist.f -o sim_csr_file; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_csr_file 2>&1)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi

echo "pass line not found in simulation output"
exit 1
